// ==== fp_add_align.sv ====
`timescale 1ns/1ps

module fp_add_align
	import fpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         rollback_en,
	input  thread_idx_t  rollback_thread,
	input  logic         in_valid,
	input  instruction_t in_instruction,
	input  vector_t      operand1,
	input  vector_t      operand2,
	output logic         out_valid,
	output instruction_t out_instruction,
	output align_vec_t   out_lanes
);
	align_vec_t lanes_next;
	logic is_subtract;
	logic accept;

	assign is_subtract = in_instruction.alu_op == op_fsub;

	// Drop rolled back threads and anything that is not add or subtract
	assign accept = in_valid
		&& !(rollback_en && rollback_thread == in_instruction.thread_idx)
		&& (in_instruction.alu_op == op_fadd || is_subtract);

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : lane_align
		ieee754_binary32_t fop1;
		ieee754_binary32_t fop2;
		significand_t sig1;
		significand_t sig2;
		logic op1_larger;
		exponent_t exp_diff;

		assign fop1 = operand1[lane];
		assign fop2 = operand2[lane];

		// Hidden bit is clear for a zero exponent
		assign sig1 = {fop1.exponent != 8'd0, fop1.significand};
		assign sig2 = {fop2.exponent != 8'd0, fop2.significand};

		// Ties keep operand 1 first, which gets the sign of signed zeros right
		assign op1_larger = fop1.exponent > fop2.exponent
			|| (fop1.exponent == fop2.exponent && sig1 >= sig2);
		assign exp_diff = op1_larger ? fop1.exponent - fop2.exponent
			: fop2.exponent - fop1.exponent;

		// Larger magnitude goes to the first slot
		assign lanes_next[lane].significand_le = op1_larger ? sig1 : sig2;
		assign lanes_next[lane].significand_se = op1_larger ? sig2 : sig1;
		assign lanes_next[lane].exponent = op1_larger ? fop1.exponent : fop2.exponent;
		// Operand 2 leading a subtract flips its sign
		assign lanes_next[lane].result_sign = op1_larger ? fop1.sign
			: fop2.sign ^ is_subtract;
		assign lanes_next[lane].logical_subtract = fop1.sign ^ fop2.sign ^ is_subtract;
		assign lanes_next[lane].shift_amount = exp_diff > exponent_t'(max_align_shift)
			? shift_amount_t'(max_align_shift) : exp_diff[4:0];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_instruction <= '0;
		end
		else
		begin
			out_valid <= accept;
			out_instruction <= in_instruction;
		end
	end

	// Datapath register
	always_ff @(posedge clk)
		out_lanes <= lanes_next;
endmodule

// ==== fp_add_normalize.sv ====
`timescale 1ns/1ps

module fp_add_normalize
	import fpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         rollback_en,
	input  thread_idx_t  rollback_thread,
	input  logic         in_valid,
	input  instruction_t in_instruction,
	input  sum_vec_t     in_lanes,
	output logic         out_valid,
	output instruction_t out_instruction,
	output norm_vec_t    out_lanes
);
	norm_vec_t lanes_next;

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : lane_norm
		sum_lane_t lane_in;
		shift_amount_t lz;
		logic carry;
		logic [8:0] exp_inc;
		exponent_t exp_carry;

		assign lane_in = in_lanes[lane];
		assign carry = lane_in.sum[27];

		// Leading zeros below the carry bit, 27 for an all-zero sum
		always_comb
		begin
			lz = 5'd27;
			for (int b = 0; b < 27; b++)
			begin
				if (lane_in.sum[b])
					lz = shift_amount_t'(26 - b);
			end
		end

		// Hold at 255 so stage 4 saturates it
		assign exp_inc = {1'b0, lane_in.exponent} + 9'd1;
		assign exp_carry = exp_inc[8] ? 8'hff : exp_inc[7:0];

		// Carry out shifts right one place, sticky keeps the dropped bit
		assign lanes_next[lane].sum = carry
			? {1'b0, lane_in.sum[27:2], lane_in.sum[1] | lane_in.sum[0]}
			: lane_in.sum << lz;
		assign lanes_next[lane].exponent = carry ? exp_carry
			: lane_in.exponent - exponent_t'(lz);
		assign lanes_next[lane].sign = lane_in.sign;

		// Subnormal or empty results flush to signed zero
		assign lanes_next[lane].zero = lane_in.sum == '0
			|| (!carry && lane_in.exponent <= exponent_t'(lz));

		// Stage 4 takes the leading one just below the carry bit
		assert property (@(posedge clk) disable iff (reset)
			out_valid && !out_lanes[lane].zero |-> out_lanes[lane].sum[27:26] == 2'b01)
			else $error("Sum not normalized in lane %0d", lane);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_instruction <= '0;
		end
		else
		begin
			out_valid <= in_valid
				&& !(rollback_en && rollback_thread == in_instruction.thread_idx);
			out_instruction <= in_instruction;
		end
	end

	always_ff @(posedge clk)
		out_lanes <= lanes_next;
endmodule

// ==== fp_add_pipeline.sv ====
`timescale 1ns/1ps

module fp_add_pipeline
	import fpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         issue_valid,
	input  instruction_t issue_instruction,
	input  vector_t      issue_operand1,
	input  vector_t      issue_operand2,
	input  logic         rollback_en,
	input  thread_idx_t  rollback_thread,
	output logic         result_valid,
	output instruction_t result_instruction,
	output vector_t      result_value
);
	// Stage 1 to stage 2
	logic align_valid;
	instruction_t align_instruction;
	align_vec_t align_lanes;

	// Stage 2 to stage 3
	logic sum_valid;
	instruction_t sum_instruction;
	sum_vec_t sum_lanes;

	// Stage 3 to stage 4
	logic norm_valid;
	instruction_t norm_instruction;
	norm_vec_t norm_lanes;

	fp_add_align u_align (
		.clk(clk),
		.reset(reset),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.in_valid(issue_valid),
		.in_instruction(issue_instruction),
		.operand1(issue_operand1),
		.operand2(issue_operand2),
		.out_valid(align_valid),
		.out_instruction(align_instruction),
		.out_lanes(align_lanes)
	);

	fp_add_shift_sum u_shift_sum (
		.clk(clk),
		.reset(reset),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.in_valid(align_valid),
		.in_instruction(align_instruction),
		.in_lanes(align_lanes),
		.out_valid(sum_valid),
		.out_instruction(sum_instruction),
		.out_lanes(sum_lanes)
	);

	fp_add_normalize u_normalize (
		.clk(clk),
		.reset(reset),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.in_valid(sum_valid),
		.in_instruction(sum_instruction),
		.in_lanes(sum_lanes),
		.out_valid(norm_valid),
		.out_instruction(norm_instruction),
		.out_lanes(norm_lanes)
	);

	// Final stage drives the result ports directly
	fp_add_round u_round (
		.clk(clk),
		.reset(reset),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.in_valid(norm_valid),
		.in_instruction(norm_instruction),
		.in_lanes(norm_lanes),
		.result_valid(result_valid),
		.result_instruction(result_instruction),
		.result_value(result_value)
	);
endmodule

// ==== fp_add_round.sv ====
`timescale 1ns/1ps

module fp_add_round
	import fpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         rollback_en,
	input  thread_idx_t  rollback_thread,
	input  logic         in_valid,
	input  instruction_t in_instruction,
	input  norm_vec_t    in_lanes,
	output logic         result_valid,
	output instruction_t result_instruction,
	output vector_t      result_value
);
	vector_t value_next;

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : lane_round
		norm_lane_t lane_in;
		logic round_up;
		logic [24:0] rounded;
		logic [8:0] exp_round;
		ieee754_binary32_t packed_val;

		assign lane_in = in_lanes[lane];

		// Nearest even, ties go up only when the LSB is set
		assign round_up = lane_in.sum[2]
			&& (lane_in.sum[1] || lane_in.sum[0] || lane_in.sum[3]);
		assign rounded = {1'b0, lane_in.sum[26:3]} + 25'(round_up);
		assign exp_round = {1'b0, lane_in.exponent} + 9'(rounded[24]);

		always_comb
		begin
			packed_val.sign = lane_in.sign;
			if (lane_in.zero)
			begin
				packed_val.exponent = 8'd0;
				packed_val.significand = 23'd0;
			end
			else if (exp_round >= 9'd255)
			begin
				// Saturate to the largest finite magnitude
				packed_val.exponent = 8'd254;
				packed_val.significand = '1;
			end
			else
			begin
				packed_val.exponent = exp_round[7:0];
				// Rounding carry renormalizes one place right
				packed_val.significand = rounded[24] ? rounded[23:1] : rounded[22:0];
			end
		end

		assign value_next[lane] = packed_val;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result_instruction <= '0;
		end
		else
		begin
			result_valid <= in_valid
				&& !(rollback_en && rollback_thread == in_instruction.thread_idx);
			result_instruction <= in_instruction;
		end
	end

	always_ff @(posedge clk)
		result_value <= value_next;
endmodule

// ==== fp_add_shift_sum.sv ====
`timescale 1ns/1ps

module fp_add_shift_sum
	import fpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         rollback_en,
	input  thread_idx_t  rollback_thread,
	input  logic         in_valid,
	input  instruction_t in_instruction,
	input  align_vec_t   in_lanes,
	output logic         out_valid,
	output instruction_t out_instruction,
	output sum_vec_t     out_lanes
);
	sum_vec_t lanes_next;

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : lane_sum
		logic [26:0] se_ext;
		logic [26:0] se_shifted;
		logic [26:0] lost_mask;
		logic sticky;
		ext_sum_t le_wide;
		ext_sum_t se_wide;
		ext_sum_t sum;

		// Append guard, round and sticky positions
		assign se_ext = {in_lanes[lane].significand_se, 3'b000};
		assign se_shifted = se_ext >> in_lanes[lane].shift_amount;

		// Everything pushed past bit 0 folds into sticky
		assign lost_mask = (27'd1 << in_lanes[lane].shift_amount) - 27'd1;
		assign sticky = |(se_ext & lost_mask);

		assign se_wide = {1'b0, se_shifted[26:1], se_shifted[0] | sticky};
		assign le_wide = {1'b0, in_lanes[lane].significand_le, 3'b000};
		assign sum = in_lanes[lane].logical_subtract ? le_wide - se_wide
			: le_wide + se_wide;

		assign lanes_next[lane].sum = sum;
		assign lanes_next[lane].exponent = in_lanes[lane].exponent;
		// Exact cancellation gives +0 whatever the operand signs
		assign lanes_next[lane].sign = in_lanes[lane].result_sign
			&& !(in_lanes[lane].logical_subtract && sum == '0);

		// Stage 1 always puts the larger magnitude first, so no borrow
		assert property (@(posedge clk) disable iff (reset)
			in_valid && in_lanes[lane].logical_subtract |-> !sum[27])
			else $error("Borrow out of subtraction in lane %0d", lane);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_instruction <= '0;
		end
		else
		begin
			out_valid <= in_valid
				&& !(rollback_en && rollback_thread == in_instruction.thread_idx);
			out_instruction <= in_instruction;
		end
	end

	always_ff @(posedge clk)
		out_lanes <= lanes_next;
endmodule

// ==== fpu_pkg.sv ====
package fpu_pkg;
	// Vector and thread geometry
	localparam int num_lanes = 4;
	localparam int num_threads = 4;

	// Larger than the significand so guard and round can shift out too
	localparam int max_align_shift = 27;

	typedef logic [num_lanes - 1:0] lane_mask_t;
	typedef logic [$clog2(num_threads) - 1:0] thread_idx_t;
	typedef logic [1:0] subcycle_t;

	// Raw binary32 word and a full vector of them
	typedef logic [31:0] float_bits_t;
	typedef float_bits_t [num_lanes - 1:0] vector_t;

	// Significand includes the hidden bit
	typedef logic [23:0] significand_t;
	typedef logic [7:0] exponent_t;
	typedef logic [4:0] shift_amount_t;

	// Carry, 24 significand bits, then guard, round and sticky
	typedef logic [27:0] ext_sum_t;

	typedef enum logic [1:0] {
		op_fadd,
		op_fsub,
		op_fmul,
		op_other
	} alu_op_t;

	// Travels beside every item down the pipeline
	typedef struct packed {
		alu_op_t alu_op;
		thread_idx_t thread_idx;
		subcycle_t subcycle;
		lane_mask_t mask;
	} instruction_t;

	typedef struct packed {
		logic sign;
		exponent_t exponent;
		logic [22:0] significand;
	} ieee754_binary32_t;

	// Stage 1 to stage 2
	typedef struct packed {
		significand_t significand_le;
		significand_t significand_se;
		shift_amount_t shift_amount;
		exponent_t exponent;
		logic logical_subtract;
		logic result_sign;
	} align_lane_t;

	// Stage 2 to stage 3
	typedef struct packed {
		ext_sum_t sum;
		exponent_t exponent;
		logic sign;
	} sum_lane_t;

	// Stage 3 to stage 4
	typedef struct packed {
		ext_sum_t sum;
		exponent_t exponent;
		logic sign;
		logic zero;
	} norm_lane_t;

	typedef align_lane_t [num_lanes - 1:0] align_vec_t;
	typedef sum_lane_t [num_lanes - 1:0] sum_vec_t;
	typedef norm_lane_t [num_lanes - 1:0] norm_vec_t;
endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fp_add -f tb.f -o tb_fp_add_sim
./obj_dir/tb_fp_add_sim > sim.log 2>&1 || true
cat sim.log

if ! grep -q "^Done: no errors$" sim.log; then
	exit 1
fi

// ==== tb.f ====
+incdir+.
fpu_pkg.sv
fp_add_align.sv
fp_add_shift_sum.sv
fp_add_normalize.sv
fp_add_round.sv
fp_add_pipeline.sv
tb_fp_add.sv

// ==== tb_fp_model.svh ====
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// Expected binary32 add or subtract of one lane
// Exponent 255 is an ordinary number, overflow saturates, subnormals flush to zero
function automatic float_bits_t model_add(input float_bits_t a, input float_bits_t b,
	input logic sub);
	logic [7:0] ea;
	logic [7:0] eb;
	logic [23:0] ma;
	logic [23:0] mb;
	logic a_big;
	logic eff_sub;
	logic sign;
	logic sticky;
	logic [26:0] small_ext;
	logic [27:0] big_ext;
	logic [27:0] small_al;
	logic [27:0] sum;
	logic [24:0] rnd;
	logic up;
	int diff;
	int e;
	int lz;
	begin
		ea = a[30:23];
		eb = b[30:23];
		ma = {ea != 8'd0, a[22:0]};
		mb = {eb != 8'd0, b[22:0]};
		a_big = (ea > eb) || (ea == eb && ma >= mb);
		diff = a_big ? int'(ea) - int'(eb) : int'(eb) - int'(ea);
		if (diff > 27)
			diff = 27;
		eff_sub = a[31] ^ b[31] ^ sub;
		sign = a_big ? a[31] : b[31] ^ sub;
		e = a_big ? int'(ea) : int'(eb);
		big_ext = {1'b0, (a_big ? ma : mb), 3'b000};
		small_ext = {(a_big ? mb : ma), 3'b000};
		// Bits shifted past position 0 all count as sticky
		sticky = 1'b0;
		for (int i = 0; i < diff; i++)
			sticky = sticky | small_ext[i];
		small_al = {1'b0, small_ext >> diff};
		small_al[0] = small_al[0] | sticky;
		sum = eff_sub ? big_ext - small_al : big_ext + small_al;
		if (eff_sub && sum == 28'd0)
			sign = 1'b0;
		if (sum == 28'd0)
			return {sign, 31'd0};
		if (sum[27])
		begin
			sum = {1'b0, sum[27:2], sum[1] | sum[0]};
			e = e + 1;
		end
		else
		begin
			lz = 0;
			while (!sum[26])
			begin
				sum = sum << 1;
				lz++;
			end
			if (e <= lz)
				return {sign, 31'd0};
			e = e - lz;
		end
		// Nearest even
		up = sum[2] & (sum[1] | sum[0] | sum[3]);
		rnd = {1'b0, sum[26:3]} + {24'd0, up};
		if (rnd[24])
			e = e + 1;
		if (e >= 255)
			return {sign, 8'd254, 23'h7fffff};
		return {sign, 8'(e), (rnd[24] ? rnd[23:1] : rnd[22:0])};
	end
endfunction

// Same rule applied to every lane
function automatic vector_t model_vec(input vector_t a, input vector_t b, input logic sub);
	vector_t r;
	begin
		for (int l = 0; l < num_lanes; l++)
			r[l] = model_add(a[l], b[l], sub);
		return r;
	end
endfunction

`endif

// ==== tb_fp_add.sv ====
`timescale 1ns/1ps

module tb_fp_add
	import fpu_pkg::*;
;
	`include "tb_fp_model.svh"

	localparam int latency = 4;
	// About 600 cycles of tests plus margin
	localparam int cycle_limit = 1200;

	logic clk;
	logic reset;
	logic issue_valid;
	instruction_t issue_instruction;
	vector_t issue_operand1;
	vector_t issue_operand2;
	logic rollback_en;
	thread_idx_t rollback_thread;
	logic result_valid;
	instruction_t result_instruction;
	vector_t result_value;

	integer seed;
	int cycle;
	string test_name;

	// Scoreboard, one entry per expected result
	vector_t value_q[$];
	instruction_t instr_q[$];
	int stamp_q[$];
	string name_q[$];

	// Head of the scoreboard, stable between rising edges
	bit head_pending;
	vector_t head_value;
	instruction_t head_instr;
	int head_stamp;
	string head_name;
	bit pop_due;

	fp_add_pipeline UUT (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_instruction(issue_instruction),
		.issue_operand1(issue_operand1),
		.issue_operand2(issue_operand2),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.result_valid(result_valid),
		.result_instruction(result_instruction),
		.result_value(result_value)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	// Result checks at the falling edge, where DUT outputs are settled
	assert property (@(negedge clk) disable iff (reset) !$isunknown(result_valid))
		else
		begin
			$display("Result valid is unknown after reset");
			abort_run();
		end

	assert property (@(negedge clk) disable iff (reset) result_valid |-> head_pending)
		else
		begin
			$display("Unexpected result with no pending item");
			abort_run();
		end

	assert property (@(negedge clk) disable iff (reset)
		result_valid && head_pending |-> result_value == head_value)
		else
		begin
			$display("Fail %s: expected value %h actual %h", head_name, head_value, result_value);
			abort_run();
		end

	assert property (@(negedge clk) disable iff (reset)
		result_valid && head_pending |-> result_instruction == head_instr)
		else
		begin
			$display("Fail %s: expected instruction %h actual %h", head_name, head_instr,
				result_instruction);
			abort_run();
		end

	assert property (@(negedge clk) disable iff (reset)
		result_valid && head_pending |-> cycle == head_stamp + latency)
		else
		begin
			$display("Fail %s: expected cycle %0d actual %0d", head_name, head_stamp + latency,
				cycle);
			abort_run();
		end

	always @(negedge clk)
		pop_due = result_valid;

	// Scoreboard upkeep and cycle count
	always @(posedge clk)
	begin
		if (pop_due && value_q.size() != 0)
		begin
			void'(value_q.pop_front());
			void'(instr_q.pop_front());
			void'(stamp_q.pop_front());
			void'(name_q.pop_front());
		end
		if (!reset && issue_valid
			&& (issue_instruction.alu_op == op_fadd || issue_instruction.alu_op == op_fsub))
		begin
			value_q.push_back(model_vec(issue_operand1, issue_operand2,
				issue_instruction.alu_op == op_fsub));
			instr_q.push_back(issue_instruction);
			stamp_q.push_back(cycle);
			name_q.push_back(test_name);
		end
		// Anything of that thread issued in the last four edges is dropped
		if (!reset && rollback_en)
		begin
			for (int i = stamp_q.size() - 1; i >= 0; i--)
			begin
				if (instr_q[i].thread_idx == rollback_thread && stamp_q[i] >= cycle - 3)
				begin
					value_q.delete(i);
					instr_q.delete(i);
					stamp_q.delete(i);
					name_q.delete(i);
				end
			end
		end
		cycle = cycle + 1;
		if (cycle >= cycle_limit)
		begin
			$display("Timeout: run exceeded %0d cycles", cycle_limit);
			abort_run();
		end
		head_pending = value_q.size() != 0;
		if (head_pending)
		begin
			head_value = value_q[0];
			head_instr = instr_q[0];
			head_stamp = stamp_q[0];
			head_name = name_q[0];
		end
	end

	function automatic vector_t make_vec(input float_bits_t l3, input float_bits_t l2,
		input float_bits_t l1, input float_bits_t l0);
		vector_t v;
		begin
			v = {l3, l2, l1, l0};
			return v;
		end
	endfunction

	// Normal numbers with exponents 1 to 200
	function automatic vector_t random_vec();
		vector_t v;
		begin
			for (int l = 0; l < num_lanes; l++)
				v[l] = {1'($random(seed)), 8'(1 + ({$random(seed)} % 200)), 23'($random(seed))};
			return v;
		end
	endfunction

	// One cycle of stimulus, 1 ns after the rising edge
	task automatic drive(input logic valid, input alu_op_t op, input thread_idx_t thr,
		input vector_t a, input vector_t b, input logic rb, input thread_idx_t rb_thr,
		input string name);
		@(posedge clk);
		#1;
		test_name = name;
		issue_valid = valid;
		issue_instruction.alu_op = op;
		issue_instruction.thread_idx = thr;
		issue_instruction.subcycle = 2'($random(seed));
		issue_instruction.mask = 4'($random(seed));
		issue_operand1 = a;
		issue_operand2 = b;
		rollback_en = rb;
		rollback_thread = rb_thr;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			issue_valid = 1'b0;
			rollback_en = 1'b0;
		end
	endtask

	initial
	begin
		seed = 54;
		cycle = 0;
		pop_due = 0;
		head_pending = 0;
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_instruction = '0;
		issue_operand1 = '0;
		issue_operand2 = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		test_name = "reset";
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		idle(5);

		// Same sign additions, last lane is a rounding tie
		drive(1, op_fadd, 0, make_vec(32'h3f800000, 32'h3fc00000, 32'hc0400000, 32'h4b800000),
			make_vec(32'h3f800000, 32'h40000000, 32'hbf800000, 32'h3f800000), 0, 0, "add_same");
		drive(1, op_fadd, 1, random_vec(), random_vec(), 0, 0, "add_random");
		idle(6);

		// Either operand larger, equal magnitudes, exponent gap above 27
		drive(1, op_fsub, 2, make_vec(32'h40400000, 32'h3f800000, 32'h40200000, 32'h4f800000),
			make_vec(32'h3f800000, 32'h40400000, 32'h40200000, 32'h3f800001), 0, 0, "sub_mixed");
		drive(1, op_fadd, 3, make_vec(32'hc0400000, 32'h3f800000, 32'hc0200000, 32'hcf800000),
			make_vec(32'h3f800000, 32'hc0400000, 32'h40200000, 32'h3fffffff), 0, 0, "add_mixed");
		idle(6);

		// Cancellation, subnormal flush and saturation
		drive(1, op_fsub, 0, make_vec(32'h3f800001, 32'h40000000, 32'h00800001, 32'h7f7fffff),
			make_vec(32'h3f800000, 32'h3fffffff, 32'h00800000, 32'hff7fffff), 0, 0, "cancel");
		drive(1, op_fadd, 1, make_vec(32'hbf800001, 32'h00c00000, 32'h80c00000, 32'h3f800000),
			make_vec(32'h3f800000, 32'h80800001, 32'h00800000, 32'hb3800000), 0, 0, "flush");
		idle(6);

		// Rollback of one thread at each edge offset of an earlier issue
		for (int k = 0; k < 4; k++)
		begin
			for (int i = 0; i < 8; i++)
				drive(1, (i % 2 != 0) ? op_fsub : op_fadd, thread_idx_t'(i % 4), random_vec(),
					random_vec(), i == 4, thread_idx_t'((4 - k) % 4), "rollback");
			idle(6);
		end

		// Filtered operations never return
		drive(1, op_fmul, 0, random_vec(), random_vec(), 0, 0, "filter_mul");
		drive(1, op_other, 1, random_vec(), random_vec(), 0, 0, "filter_other");
		idle(6);

		// Continuous stream, four items in flight
		for (int i = 0; i < 400; i++)
			drive(1, ($random(seed) & 1) ? op_fsub : op_fadd, thread_idx_t'($random(seed)),
				random_vec(), random_vec(), 0, 0, "stream");
		idle(1);

		repeat (6) @(posedge clk);
		if (value_q.size() == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("Results still pending at end of run");
			abort_run();
		end
	end
endmodule
